/* hdl/shadowPkg.sv */
// Both scene word views are 48 bits only while coordinates, addresses and counts stay 8 bits
package shadowPkg;

    localparam int COORD_WIDTH = 8;
    localparam int ADDR_WIDTH = 8;
    localparam int COUNT_WIDTH = 8;
    localparam int COLOR_WIDTH = 24;
    localparam int SCENE_WIDTH = 6 * COORD_WIDTH;

    // Global group at a fixed place in the scene layout
    localparam logic [ADDR_WIDTH-1:0] GLOBAL_START = ADDR_WIDTH'(8);
    localparam logic [COUNT_WIDTH-1:0] GLOBAL_COUNT = COUNT_WIDTH'(3);

    typedef enum logic [1:0] {
        stNone,
        stDiffuse,
        stMirror
    } surfaceType_t;

    typedef struct packed {
        logic [COORD_WIDTH-1:0] xMin;
        logic [COORD_WIDTH-1:0] xMax;
        logic [COORD_WIDTH-1:0] yMin;
        logic [COORD_WIDTH-1:0] yMax;
        logic [COORD_WIDTH-1:0] zMin;
        logic [COORD_WIDTH-1:0] zMax;
    } boxView_t;

    // Two leaf groups per tile with padding in the low bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] leaf0Start;
        logic [COUNT_WIDTH-1:0] leaf0Count;
        logic [ADDR_WIDTH-1:0] leaf1Start;
        logic [COUNT_WIDTH-1:0] leaf1Count;
        logic [SCENE_WIDTH-2*ADDR_WIDTH-2*COUNT_WIDTH-1:0] unused;
    } tileView_t;

    typedef union packed {
        boxView_t box;
        tileView_t tile;
    } sceneWord_t;

    typedef enum logic [1:0] {
        shInit,
        shTrace,
        shDone
    } shadowState_t;

endpackage

/* hdl/sceneMemory.sv */
// No reset and no read-during-write bypass; a read returns the old word one cycle later
module sceneMemory #(
    parameter int MEM_WORDS = 256
) (
    input  logic clk,
    input  logic memRdEn,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] memRdAddr,
    input  logic memWrEn,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] memAddr,
    input  shadowPkg::sceneWord_t memWrData,
    output shadowPkg::sceneWord_t memRdData
);
    import shadowPkg::*;

    sceneWord_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (memWrEn) begin
            mem[memAddr] <= memWrData;
        end
        // Registered read port
        if (memRdEn) begin
            memRdData <= mem[memRdAddr];
        end
    end

endmodule

/* hdl/sceneArbiter.sv */
// Tile reader always wins; a requester must hold its request until granted
module sceneArbiter (
    input  logic clk,
    input  logic resetn,
    input  logic tileReq,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] tileAddr,
    input  logic primReq,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] primAddr,
    input  shadowPkg::sceneWord_t memRdData,
    output logic tileGrant,
    output logic primGrant,
    output logic tileRdValid,
    output logic primRdValid,
    output shadowPkg::sceneWord_t tileRdData,
    output shadowPkg::sceneWord_t primRdData,
    output logic memRdEn,
    output logic [shadowPkg::ADDR_WIDTH-1:0] memRdAddr
);
    logic rdPending;
    logic ownerTile;

    // Grant in the request cycle
    assign tileGrant = tileReq;
    assign primGrant = primReq && !tileReq;
    assign memRdEn = tileReq || primReq;
    assign memRdAddr = tileReq ? tileAddr : primAddr;

    // Word comes back one cycle later to whoever asked
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rdPending <= 1'b0;
            ownerTile <= 1'b0;
        end else begin
            rdPending <= memRdEn;
            ownerTile <= tileReq;
        end
    end

    assign tileRdValid = rdPending && ownerTile;
    assign primRdValid = rdPending && !ownerTile;
    assign tileRdData = memRdData;
    assign primRdData = memRdData;

endmodule

/* hdl/tileReader.sv */
// QUEUE_DEPTH must be a power of two of at least 4; traceStart drops anything still queued
module tileReader #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic clk,
    input  logic resetn,
    input  logic traceStart,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] rayTile,
    input  logic tileGrant,
    input  logic tileRdValid,
    input  shadowPkg::sceneWord_t tileRdData,
    input  logic groupPop,
    output logic tileReq,
    output logic [shadowPkg::ADDR_WIDTH-1:0] tileAddr,
    output logic queueReady,
    output logic groupAvail,
    output logic [shadowPkg::ADDR_WIDTH-1:0] groupStart,
    output logic [shadowPkg::COUNT_WIDTH-1:0] groupCount
);
    import shadowPkg::*;

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int LEVEL_WIDTH = $clog2(QUEUE_DEPTH + 1);

    logic [ADDR_WIDTH-1:0] qStart [QUEUE_DEPTH];
    logic [COUNT_WIDTH-1:0] qCount [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    logic [LEVEL_WIDTH-1:0] level;
    logic push0;
    logic push1;
    logic popValid;

    // Empty leaves never reach the queue
    assign push0 = tileRdValid && (tileRdData.tile.leaf0Count != '0);
    assign push1 = tileRdValid && (tileRdData.tile.leaf1Count != '0);
    assign popValid = groupPop && groupAvail;

    assign groupAvail = (level != '0);
    assign groupStart = qStart[head];
    assign groupCount = qCount[head];

    // --------------------------------------------------
    // Queue storage and descriptor address
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (traceStart) begin
            qStart[0] <= GLOBAL_START;
            qCount[0] <= GLOBAL_COUNT;
            tileAddr <= rayTile;
        end else begin
            if (push0) begin
                qStart[tail] <= tileRdData.tile.leaf0Start;
                qCount[tail] <= tileRdData.tile.leaf0Count;
            end
            // Leaf 1 goes behind leaf 0 when both are present
            if (push1) begin
                qStart[tail + PTR_WIDTH'(push0)] <= tileRdData.tile.leaf1Start;
                qCount[tail + PTR_WIDTH'(push0)] <= tileRdData.tile.leaf1Count;
            end
        end
    end

    // --------------------------------------------------
    // Pointers, fetch request and ready pulse
    // --------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            head <= '0;
            tail <= '0;
            level <= '0;
            tileReq <= 1'b0;
            queueReady <= 1'b0;
        end else begin
            queueReady <= tileRdValid;
            if (traceStart) begin
                // Global group already sits in slot 0
                head <= '0;
                tail <= PTR_WIDTH'(1);
                level <= LEVEL_WIDTH'(1);
                tileReq <= 1'b1;
            end else begin
                if (tileGrant) begin
                    tileReq <= 1'b0;
                end
                if (popValid) begin
                    head <= head + PTR_WIDTH'(1);
                end
                tail <= tail + PTR_WIDTH'(push0) + PTR_WIDTH'(push1);
                level <= level + LEVEL_WIDTH'(push0) + LEVEL_WIDTH'(push1)
                         - LEVEL_WIDTH'(popValid);
            end
        end
    end

endmodule

/* hdl/occlusionTester.sv */
// Ray points straight up; queued groups must have a nonzero count, stops at the first hit
module occlusionTester (
    input  logic clk,
    input  logic resetn,
    input  logic queueReady,
    input  logic [shadowPkg::COORD_WIDTH-1:0] rayX,
    input  logic [shadowPkg::COORD_WIDTH-1:0] rayY,
    input  logic [shadowPkg::COORD_WIDTH-1:0] rayZ,
    input  logic groupAvail,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] groupStart,
    input  logic [shadowPkg::COUNT_WIDTH-1:0] groupCount,
    input  logic primGrant,
    input  logic primRdValid,
    input  shadowPkg::sceneWord_t primRdData,
    output logic groupPop,
    output logic primReq,
    output logic [shadowPkg::ADDR_WIDTH-1:0] primAddr,
    output logic traceDone,
    output logic hit
);
    import shadowPkg::*;

    localparam logic [1:0] TEST_IDLE = 2'd0;
    localparam logic [1:0] TEST_NEXT = 2'd1;
    localparam logic [1:0] TEST_REQ = 2'd2;
    localparam logic [1:0] TEST_WAIT = 2'd3;

    logic [1:0] testState;
    logic [ADDR_WIDTH-1:0] boxAddr;
    logic [COUNT_WIDTH-1:0] boxesLeft;
    boxView_t box;
    logic occluded;

    assign box = primRdData.box;

    // Footprint covers the ray and the box top lies above the fragment
    assign occluded = (box.xMin <= rayX) && (rayX <= box.xMax)
                   && (box.yMin <= rayY) && (rayY <= box.yMax)
                   && (box.zMax > rayZ);

    assign groupPop = (testState == TEST_NEXT) && groupAvail;
    assign primReq = (testState == TEST_REQ);
    assign primAddr = boxAddr;

    // Box cursor inside the current group
    always_ff @(posedge clk) begin
        if (groupPop) begin
            boxAddr <= groupStart;
            boxesLeft <= groupCount;
        end else if (primRdValid) begin
            boxAddr <= boxAddr + ADDR_WIDTH'(1);
            boxesLeft <= boxesLeft - COUNT_WIDTH'(1);
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            testState <= TEST_IDLE;
            traceDone <= 1'b0;
            hit <= 1'b0;
        end else begin
            traceDone <= 1'b0;
            case (testState)
                TEST_IDLE: begin
                    if (queueReady) begin
                        testState <= TEST_NEXT;
                    end
                end
                TEST_NEXT: begin
                    if (groupAvail) begin
                        testState <= TEST_REQ;
                    end else begin
                        // Queue drained without a hit
                        traceDone <= 1'b1;
                        hit <= 1'b0;
                        testState <= TEST_IDLE;
                    end
                end
                TEST_REQ: begin
                    if (primGrant) begin
                        testState <= TEST_WAIT;
                    end
                end
                default: begin
                    if (primRdValid) begin
                        if (occluded) begin
                            traceDone <= 1'b1;
                            hit <= 1'b1;
                            testState <= TEST_IDLE;
                        end else if (boxesLeft == COUNT_WIDTH'(1)) begin
                            testState <= TEST_NEXT;
                        end else begin
                            testState <= TEST_REQ;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/fragmentControl.sv */
// One buffered fragment at a time; output fields hold until the next valid pulse
module fragmentControl (
    input  logic clk,
    input  logic resetn,
    input  logic addInput,
    input  logic [shadowPkg::COORD_WIDTH-1:0] x,
    input  logic [shadowPkg::COORD_WIDTH-1:0] y,
    input  logic [shadowPkg::COORD_WIDTH-1:0] z,
    input  shadowPkg::surfaceType_t surface,
    input  logic [shadowPkg::COLOR_WIDTH-1:0] color,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] tileIndex,
    input  logic outputFifoFull,
    input  logic traceDone,
    input  logic hit,
    output logic fifoFull,
    output logic valid,
    output logic [shadowPkg::COORD_WIDTH-1:0] outX,
    output logic [shadowPkg::COORD_WIDTH-1:0] outY,
    output logic [shadowPkg::COORD_WIDTH-1:0] outZ,
    output shadowPkg::surfaceType_t outSurface,
    output logic [shadowPkg::COLOR_WIDTH-1:0] outColor,
    output logic outInShadow,
    output logic traceStart,
    output logic [shadowPkg::COORD_WIDTH-1:0] rayX,
    output logic [shadowPkg::COORD_WIDTH-1:0] rayY,
    output logic [shadowPkg::COORD_WIDTH-1:0] rayZ,
    output logic [shadowPkg::ADDR_WIDTH-1:0] rayTile
);
    import shadowPkg::*;

    shadowState_t state;
    logic [COORD_WIDTH-1:0] bufX;
    logic [COORD_WIDTH-1:0] bufY;
    logic [COORD_WIDTH-1:0] bufZ;
    surfaceType_t bufSurface;
    surfaceType_t curSurface;
    logic [COLOR_WIDTH-1:0] bufColor;
    logic [COLOR_WIDTH-1:0] curColor;
    logic [ADDR_WIDTH-1:0] bufTile;
    logic anyHit;
    logic accept;
    logic take;
    logic emit;

    assign accept = addInput && !fifoFull;
    assign take = (state == shInit) && fifoFull;
    assign emit = (state == shDone) && !outputFifoFull;

    // --------------------------------------------------
    // Input buffer, working fragment, output register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            bufX <= x;
            bufY <= y;
            bufZ <= z;
            bufSurface <= surface;
            bufColor <= color;
            bufTile <= tileIndex;
        end
        if (take) begin
            rayX <= bufX;
            rayY <= bufY;
            rayZ <= bufZ;
            rayTile <= bufTile;
            curSurface <= bufSurface;
            curColor <= bufColor;
        end
        if (emit) begin
            outX <= rayX;
            outY <= rayY;
            outZ <= rayZ;
            outSurface <= curSurface;
            outColor <= curColor;
            outInShadow <= anyHit;
        end
    end

    // --------------------------------------------------
    // Per-fragment FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= shInit;
            fifoFull <= 1'b0;
            valid <= 1'b0;
            traceStart <= 1'b0;
            anyHit <= 1'b0;
        end else begin
            valid <= 1'b0;
            traceStart <= 1'b0;
            if (accept) begin
                fifoFull <= 1'b1;
            end
            case (state)
                shInit: begin
                    if (take) begin
                        fifoFull <= 1'b0;
                        anyHit <= 1'b0;
                        // Background fragments skip the trace
                        if (bufSurface == stNone) begin
                            state <= shDone;
                        end else begin
                            traceStart <= 1'b1;
                            state <= shTrace;
                        end
                    end
                end
                shTrace: begin
                    if (traceDone) begin
                        anyHit <= hit;
                        state <= shDone;
                    end
                end
                shDone: begin
                    if (emit) begin
                        valid <= 1'b1;
                        state <= shInit;
                    end
                end
                default: state <= shInit;
            endcase
        end
    end

endmodule

/* hdl/shadowUnit.sv */
// Scene memory may only be written while no fragment is in flight
module shadowUnit #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS = 256
) (
    input  logic clk,
    input  logic resetn,
    input  logic addInput,
    input  logic [shadowPkg::COORD_WIDTH-1:0] x,
    input  logic [shadowPkg::COORD_WIDTH-1:0] y,
    input  logic [shadowPkg::COORD_WIDTH-1:0] z,
    input  shadowPkg::surfaceType_t surface,
    input  logic [shadowPkg::COLOR_WIDTH-1:0] color,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] tileIndex,
    input  logic outputFifoFull,
    input  logic memWrEn,
    input  logic [shadowPkg::ADDR_WIDTH-1:0] memAddr,
    input  shadowPkg::sceneWord_t memWrData,
    output logic fifoFull,
    output logic valid,
    output logic [shadowPkg::COORD_WIDTH-1:0] outX,
    output logic [shadowPkg::COORD_WIDTH-1:0] outY,
    output logic [shadowPkg::COORD_WIDTH-1:0] outZ,
    output shadowPkg::surfaceType_t outSurface,
    output logic [shadowPkg::COLOR_WIDTH-1:0] outColor,
    output logic outInShadow
);
    import shadowPkg::*;

    // Control to peers
    logic traceStart, traceDone, hit, queueReady;
    logic [COORD_WIDTH-1:0] rayX, rayY, rayZ;
    logic [ADDR_WIDTH-1:0] rayTile;

    // Group queue
    logic groupAvail, groupPop;
    logic [ADDR_WIDTH-1:0] groupStart;
    logic [COUNT_WIDTH-1:0] groupCount;

    // Scene reads
    logic tileReq, tileGrant, tileRdValid;
    logic primReq, primGrant, primRdValid;
    logic [ADDR_WIDTH-1:0] tileAddr, primAddr, memRdAddr;
    logic memRdEn;
    sceneWord_t tileRdData, primRdData, memRdData;

    fragmentControl fragmentControl_inst (
        .clk(clk), .resetn(resetn), .addInput(addInput),
        .x(x), .y(y), .z(z), .surface(surface), .color(color), .tileIndex(tileIndex),
        .outputFifoFull(outputFifoFull), .traceDone(traceDone), .hit(hit),
        .fifoFull(fifoFull), .valid(valid),
        .outX(outX), .outY(outY), .outZ(outZ), .outSurface(outSurface),
        .outColor(outColor), .outInShadow(outInShadow), .traceStart(traceStart),
        .rayX(rayX), .rayY(rayY), .rayZ(rayZ), .rayTile(rayTile)
    );

    tileReader #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) tileReader_inst (
        .clk(clk), .resetn(resetn), .traceStart(traceStart), .rayTile(rayTile),
        .tileGrant(tileGrant), .tileRdValid(tileRdValid), .tileRdData(tileRdData),
        .groupPop(groupPop), .tileReq(tileReq), .tileAddr(tileAddr),
        .queueReady(queueReady), .groupAvail(groupAvail),
        .groupStart(groupStart), .groupCount(groupCount)
    );

    occlusionTester occlusionTester_inst (
        .clk(clk), .resetn(resetn), .queueReady(queueReady),
        .rayX(rayX), .rayY(rayY), .rayZ(rayZ),
        .groupAvail(groupAvail), .groupStart(groupStart), .groupCount(groupCount),
        .primGrant(primGrant), .primRdValid(primRdValid), .primRdData(primRdData),
        .groupPop(groupPop), .primReq(primReq), .primAddr(primAddr),
        .traceDone(traceDone), .hit(hit)
    );

    sceneArbiter sceneArbiter_inst (
        .clk(clk), .resetn(resetn),
        .tileReq(tileReq), .tileAddr(tileAddr), .primReq(primReq), .primAddr(primAddr),
        .memRdData(memRdData), .tileGrant(tileGrant), .primGrant(primGrant),
        .tileRdValid(tileRdValid), .primRdValid(primRdValid),
        .tileRdData(tileRdData), .primRdData(primRdData),
        .memRdEn(memRdEn), .memRdAddr(memRdAddr)
    );

    sceneMemory #(
        .MEM_WORDS(MEM_WORDS)
    ) sceneMemory_inst (
        .clk(clk), .memRdEn(memRdEn), .memRdAddr(memRdAddr),
        .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
        .memRdData(memRdData)
    );

endmodule

/* sim/shadowUnitTb.sv */
// Needs a simulator with concurrent assertions; the scene is loaded once, before the first fragment
module shadowUnitTb;
    import shadowPkg::*;

    localparam int WAIT_LIMIT = 400;
    localparam int HOLD_CYCLES = 60;
    localparam int RANDOM_FRAGMENTS = 48;

    typedef struct packed {
        logic [COORD_WIDTH-1:0] x;
        logic [COORD_WIDTH-1:0] y;
        logic [COORD_WIDTH-1:0] z;
        surfaceType_t surface;
        logic [COLOR_WIDTH-1:0] color;
        logic inShadow;
    } fragExp_t;

    logic clk;
    logic resetn;
    logic addInput;
    logic [COORD_WIDTH-1:0] x;
    logic [COORD_WIDTH-1:0] y;
    logic [COORD_WIDTH-1:0] z;
    surfaceType_t surface;
    logic [COLOR_WIDTH-1:0] color;
    logic [ADDR_WIDTH-1:0] tileIndex;
    logic outputFifoFull;
    logic memWrEn;
    logic [ADDR_WIDTH-1:0] memAddr;
    sceneWord_t memWrData;
    logic fifoFull;
    logic valid;
    logic [COORD_WIDTH-1:0] outX;
    logic [COORD_WIDTH-1:0] outY;
    logic [COORD_WIDTH-1:0] outZ;
    surfaceType_t outSurface;
    logic [COLOR_WIDTH-1:0] outColor;
    logic outInShadow;

    // Mirror of every scene word written into the DUT
    sceneWord_t refMem [1 << ADDR_WIDTH];
    fragExp_t expQ [$];
    fragExp_t pending;
    fragExp_t popped;
    int acceptCount = 0;
    int resultCount = 0;
    logic lastInShadow = 1'b0;
    logic [31:0] lfsrState = 32'h4886;

    shadowUnit #(
        .QUEUE_DEPTH(4),
        .MEM_WORDS(256)
    ) shadowUnit_inst (
        .clk(clk), .resetn(resetn), .addInput(addInput),
        .x(x), .y(y), .z(z), .surface(surface), .color(color), .tileIndex(tileIndex),
        .outputFifoFull(outputFifoFull),
        .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
        .fifoFull(fifoFull), .valid(valid), .outX(outX), .outY(outY), .outZ(outZ),
        .outSurface(outSurface), .outColor(outColor), .outInShadow(outInShadow)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic reportFailure(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic valueError(input string msg);
        reportFailure($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    // --------------------------------------------------
    // LFSR and reference model
    // --------------------------------------------------
    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // Vertical ray hits when the point lies inside the footprint and under the top face
    function automatic logic boxCovers(input boxView_t b, input logic [COORD_WIDTH-1:0] px,
                                       input logic [COORD_WIDTH-1:0] py,
                                       input logic [COORD_WIDTH-1:0] pz);
        logic inFootprint;
        inFootprint = (px >= b.xMin) && (px <= b.xMax) && (py >= b.yMin) && (py <= b.yMax);
        return inFootprint && (pz < b.zMax);
    endfunction

    function automatic logic groupShadows(input logic [ADDR_WIDTH-1:0] start,
                                          input logic [COUNT_WIDTH-1:0] count,
                                          input logic [COORD_WIDTH-1:0] px,
                                          input logic [COORD_WIDTH-1:0] py,
                                          input logic [COORD_WIDTH-1:0] pz);
        logic any;
        any = 1'b0;
        for (int i = 0; i < int'(count); i++) begin
            any = any | boxCovers(refMem[start + ADDR_WIDTH'(i)].box, px, py, pz);
        end
        return any;
    endfunction

    // An empty leaf contributes nothing, so all three groups can be scanned
    function automatic logic shadowRef(input logic [COORD_WIDTH-1:0] px,
                                       input logic [COORD_WIDTH-1:0] py,
                                       input logic [COORD_WIDTH-1:0] pz,
                                       input surfaceType_t s,
                                       input logic [ADDR_WIDTH-1:0] tile);
        tileView_t t;
        t = refMem[tile].tile;
        if (s == stNone) begin
            return 1'b0;
        end
        return groupShadows(GLOBAL_START, GLOBAL_COUNT, px, py, pz)
             | groupShadows(t.leaf0Start, t.leaf0Count, px, py, pz)
             | groupShadows(t.leaf1Start, t.leaf1Count, px, py, pz);
    endfunction

    // --------------------------------------------------
    // Scene loading and fragment driving
    // --------------------------------------------------
    task automatic writeScene(input logic [ADDR_WIDTH-1:0] addr, input sceneWord_t word);
        memWrEn = 1'b1;
        memAddr = addr;
        memWrData = word;
        refMem[addr] = word;
        @(negedge clk);
        memWrEn = 1'b0;
    endtask

    task automatic putBox(input int addr, input int xMin, input int xMax, input int yMin,
                          input int yMax, input int zMax);
        sceneWord_t w;
        w = '0;
        w.box.xMin = COORD_WIDTH'(xMin);
        w.box.xMax = COORD_WIDTH'(xMax);
        w.box.yMin = COORD_WIDTH'(yMin);
        w.box.yMax = COORD_WIDTH'(yMax);
        w.box.zMax = COORD_WIDTH'(zMax);
        writeScene(ADDR_WIDTH'(addr), w);
    endtask

    task automatic putTile(input int addr, input int start0, input int count0,
                           input int start1, input int count1);
        sceneWord_t w;
        w = '0;
        w.tile.leaf0Start = ADDR_WIDTH'(start0);
        w.tile.leaf0Count = COUNT_WIDTH'(count0);
        w.tile.leaf1Start = ADDR_WIDTH'(start1);
        w.tile.leaf1Count = COUNT_WIDTH'(count1);
        writeScene(ADDR_WIDTH'(addr), w);
    endtask

    task automatic sendFragment(input int fx, input int fy, input int fz, input surfaceType_t fs,
                                input int fcolor, input int ftile);
        int cycles;
        cycles = 0;
        while (fifoFull) begin
            if (cycles == WAIT_LIMIT) begin
                reportFailure("Timed out waiting for fifoFull to clear");
            end
            @(negedge clk);
            cycles++;
        end
        addInput = 1'b1;
        x = COORD_WIDTH'(fx);
        y = COORD_WIDTH'(fy);
        z = COORD_WIDTH'(fz);
        surface = fs;
        color = COLOR_WIDTH'(fcolor);
        tileIndex = ADDR_WIDTH'(ftile);
        @(negedge clk);
        addInput = 1'b0;
    endtask

    task automatic waitResults(input int target);
        int cycles;
        cycles = 0;
        while (resultCount < target) begin
            if (cycles == WAIT_LIMIT) begin
                reportFailure("Timed out waiting for a valid result");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic traceAndCheck(input int fx, input int fy, input int fz, input surfaceType_t fs,
                                 input int ftile, input logic expectShadow);
        int base;
        base = resultCount;
        sendFragment(fx, fy, fz, fs, int'(takeBits(24)), ftile);
        waitResults(base + 1);
        assert (lastInShadow == expectShadow)
            else valueError($sformatf("fragment (%0d,%0d,%0d) tile %0d: inShadow %0b, want %0b",
                                      fx, fy, fz, ftile, lastInShadow, expectShadow));
    endtask

    // --------------------------------------------------
    // Result monitor and protocol checks
    // --------------------------------------------------
    always @(posedge clk) begin
        if (resetn) begin
            if (addInput && !fifoFull) begin
                pending.x = x;
                pending.y = y;
                pending.z = z;
                pending.surface = surface;
                pending.color = color;
                pending.inShadow = shadowRef(x, y, z, surface, tileIndex);
                expQ.push_back(pending);
                acceptCount++;
            end
            if (valid) begin
                assert (expQ.size() != 0) else valueError("valid with no fragment outstanding");
                popped = expQ.pop_front();
                assert (outX == popped.x && outY == popped.y && outZ == popped.z
                        && outSurface == popped.surface && outColor == popped.color
                        && outInShadow == popped.inShadow)
                    else valueError($sformatf(
                        "got (%0d,%0d,%0d) s%0d c%h sh%0b, want (%0d,%0d,%0d) s%0d c%h sh%0b",
                        outX, outY, outZ, outSurface, outColor, outInShadow,
                        popped.x, popped.y, popped.z, popped.surface,
                        popped.color, popped.inShadow));
                lastInShadow = outInShadow;
                resultCount++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) valid |-> !$past(outputFifoFull))
        else valueError("valid raised while outputFifoFull was high");

    assert property (@(posedge clk) disable iff (!resetn) valid |=> !valid)
        else valueError("valid held for more than one cycle");

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int base;
        int cycles;
        logic [1:0] pick;
        resetn = 1'b0;
        addInput = 1'b0;
        x = '0;
        y = '0;
        z = '0;
        surface = stNone;
        color = '0;
        tileIndex = '0;
        outputFifoFull = 1'b0;
        memWrEn = 1'b0;
        memAddr = '0;
        memWrData = '0;
        repeat (4) @(negedge clk);
        assert (!fifoFull && !valid) else valueError("fifoFull or valid high in reset");
        resetn = 1'b1;
        @(negedge clk);
        assert (!fifoFull && !valid) else valueError("fifoFull or valid high after reset");

        // Global boxes, leaf boxes, then four tiles
        putBox(int'(GLOBAL_START), 10, 60, 10, 60, 80);
        putBox(int'(GLOBAL_START) + 1, 100, 180, 20, 120, 150);
        putBox(int'(GLOBAL_START) + 2, 40, 140, 150, 250, 200);
        putBox(16, 180, 250, 0, 100, 120);
        putBox(17, 0, 90, 120, 200, 60);
        putBox(24, 200, 255, 180, 255, 220);
        putBox(32, 150, 255, 100, 180, 180);
        putBox(33, 60, 100, 60, 100, 255);
        putBox(40, 0, 255, 0, 255, 40);
        putTile(0, 0, 0, 0, 0);
        putTile(1, 16, 2, 24, 1);
        putTile(2, 0, 0, 32, 2);
        putTile(3, 40, 1, 0, 0);

        // Background passes through, then global box hit, beside and above
        traceAndCheck(30, 30, 20, stNone, 0, 1'b0);
        traceAndCheck(30, 30, 20, stDiffuse, 0, 1'b1);
        traceAndCheck(70, 30, 20, stMirror, 0, 1'b0);
        traceAndCheck(30, 30, 90, stDiffuse, 0, 1'b0);
        traceAndCheck(30, 30, 80, stDiffuse, 0, 1'b0);
        // Leaf 1 only occluder, and the same point over an empty tile
        traceAndCheck(200, 140, 50, stDiffuse, 2, 1'b1);
        traceAndCheck(200, 140, 50, stDiffuse, 0, 1'b0);

        // Back-pressure holds the result
        outputFifoFull = 1'b1;
        base = resultCount;
        sendFragment(120, 50, 10, stMirror, 24'h00ff00, 1);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (!valid) else valueError("valid while outputFifoFull high");
        end
        outputFifoFull = 1'b0;
        waitResults(base + 1);
        // Room for a second valid to show up in the monitor
        repeat (20) @(negedge clk);
        assert (lastInShadow) else valueError("held fragment not shadowed");

        // Random fragments with random back-pressure
        base = acceptCount;
        cycles = 0;
        while (acceptCount < base + RANDOM_FRAGMENTS) begin
            if (cycles == RANDOM_FRAGMENTS * 60) begin
                reportFailure("Random fragments were not all accepted in time");
            end
            addInput = 1'(takeBits(1));
            x = COORD_WIDTH'(takeBits(8));
            y = COORD_WIDTH'(takeBits(8));
            z = COORD_WIDTH'(takeBits(8));
            pick = 2'(takeBits(2));
            surface = (pick == 2'd3) ? stDiffuse : surfaceType_t'(pick);
            color = COLOR_WIDTH'(takeBits(24));
            tileIndex = ADDR_WIDTH'(takeBits(2));
            outputFifoFull = (takeBits(2) == 32'd0);
            @(negedge clk);
            cycles++;
        end
        addInput = 1'b0;
        outputFifoFull = 1'b0;
        waitResults(acceptCount);
        repeat (20) @(negedge clk);

        $display("No errors");
        $finish;
    end

endmodule

/* filelist.f */
hdl/shadowPkg.sv
hdl/sceneMemory.sv
hdl/sceneArbiter.sv
hdl/tileReader.sv
hdl/occlusionTester.sv
hdl/fragmentControl.sv
hdl/shadowUnit.sv
sim/shadowUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= shadowUnitTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BINARY)
	./$(BINARY)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
